// ==== flist.f ====
+incdir+verif
source/exe_pkg.sv
source/exe_alu.sv
source/exe_stage.sv
source/exe_result_queue.sv
source/exe_top.sv
verif/tb_exe_top.sv

// ==== run.sh ====
#!/bin/sh
# build and run the execute stage testbench with verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 --top-module tb_exe_top \
	-f flist.f -o sim_tb_exe_top
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

out=$(./obj_dir/sim_tb_exe_top)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

printf '%s\n' "$out" | grep -qx "STATUS: PASS" || exit 1
exit 0

// ==== source/exe_alu.sv ====
// integer alu
`timescale 1ns/1ps
`default_nettype none

module exe_alu import exe_pkg::*; (
	input  wire logic [XLEN-1:0]     src1_i,
	input  wire logic [XLEN-1:0]     src2_i,
	input  wire logic [ALU_OP_W-1:0] alu_ctrl_i,
	output logic      [XLEN-1:0]     result_o,
	output logic                     less_o,
	output logic                     zero_o
);

	logic       lt_signed;
	logic       lt_unsigned;
	logic [4:0] shamt;

	assign lt_signed   = $signed(src1_i) < $signed(src2_i);
	assign lt_unsigned = src1_i < src2_i;

	// rv32 shifts only look at the low five bits
	assign shamt = src2_i[4:0];

	always_comb begin
		case (alu_ctrl_i)
			ALU_ADD:  result_o = src1_i + src2_i;
			ALU_SUB:  result_o = src1_i - src2_i;
			ALU_AND:  result_o = src1_i & src2_i;
			ALU_OR:   result_o = src1_i | src2_i;
			ALU_XOR:  result_o = src1_i ^ src2_i;
			ALU_SLL:  result_o = src1_i << shamt;
			ALU_SRL:  result_o = src1_i >> shamt;
			ALU_SRA:  result_o = $signed(src1_i) >>> shamt;
			ALU_SLT:  result_o = {{(XLEN-1){1'b0}}, lt_signed};
			ALU_SLTU: result_o = {{(XLEN-1){1'b0}}, lt_unsigned};
			default:  result_o = '0;
		endcase
	end

	// less flag feeds the branch compare
	always_comb begin
		case (alu_ctrl_i)
			ALU_SUB,
			ALU_SLT:  less_o = lt_signed;
			ALU_SLTU: less_o = lt_unsigned;
			default:  less_o = 1'b0;
		endcase
	end

	assign zero_o = (result_o == '0);

endmodule

`default_nettype wire

// ==== source/exe_pkg.sv ====
// execute stage definitions
`default_nettype none

package exe_pkg;

	// data and field widths
	localparam int XLEN       = 32;
	localparam int ALU_OP_W   = 4;
	localparam int SEL_W      = 2;
	localparam int BR_W       = 3;
	localparam int CSR_W      = 3;
	localparam int LOAD_W     = 3;
	localparam int STORE_W    = 2;
	localparam int REG_ADDR_W = 5;

	// alu control codes
	localparam logic [ALU_OP_W-1:0] ALU_ADD  = 4'd0;
	localparam logic [ALU_OP_W-1:0] ALU_SUB  = 4'd1;
	localparam logic [ALU_OP_W-1:0] ALU_AND  = 4'd2;
	localparam logic [ALU_OP_W-1:0] ALU_OR   = 4'd3;
	localparam logic [ALU_OP_W-1:0] ALU_XOR  = 4'd4;
	localparam logic [ALU_OP_W-1:0] ALU_SLL  = 4'd5;
	localparam logic [ALU_OP_W-1:0] ALU_SRL  = 4'd6;
	localparam logic [ALU_OP_W-1:0] ALU_SRA  = 4'd7;
	localparam logic [ALU_OP_W-1:0] ALU_SLT  = 4'd8;
	localparam logic [ALU_OP_W-1:0] ALU_SLTU = 4'd9;

	// operand sources, first in the low field of alu_sel
	localparam logic [SEL_W-1:0] SEL1_ZERO = 2'd0;
	localparam logic [SEL_W-1:0] SEL1_REG1 = 2'd1;
	localparam logic [SEL_W-1:0] SEL1_PC   = 2'd2;
	localparam logic [SEL_W-1:0] SEL1_CSR  = 2'd3;
	localparam logic [SEL_W-1:0] SEL2_ZERO = 2'd0;
	localparam logic [SEL_W-1:0] SEL2_REG2 = 2'd1;
	localparam logic [SEL_W-1:0] SEL2_IMM  = 2'd2;
	localparam logic [SEL_W-1:0] SEL2_FOUR = 2'd3;

	// conditional branch types
	localparam logic [BR_W-1:0] BR_NONE = 3'd0;
	localparam logic [BR_W-1:0] BR_BEQ  = 3'd1;
	localparam logic [BR_W-1:0] BR_BNE  = 3'd2;
	localparam logic [BR_W-1:0] BR_BLT  = 3'd3;
	localparam logic [BR_W-1:0] BR_BGE  = 3'd4;
	localparam logic [BR_W-1:0] BR_BLTU = 3'd5;
	localparam logic [BR_W-1:0] BR_BGEU = 3'd6;

	// csr access kinds
	localparam logic [CSR_W-1:0] CSR_NONE = 3'd0;
	localparam logic [CSR_W-1:0] CSR_RW   = 3'd1;
	localparam logic [CSR_W-1:0] CSR_RS   = 3'd2;

	// queue and credit sizing
	localparam int QUEUE_DEPTH = 4;
	localparam int MEM_CREDITS = 2;
	localparam int QPTR_W      = $clog2(QUEUE_DEPTH);
	localparam int QCNT_W      = $clog2(QUEUE_DEPTH + 1);
	localparam int MCRED_W     = $clog2(MEM_CREDITS + 1);

	// alu, csr data + type, pc, branch, load, store, mem data, wreg, wd
	localparam int RESULT_W = XLEN + (XLEN + CSR_W) + XLEN + 1
		+ (LOAD_W + STORE_W + XLEN) + REG_ADDR_W + 1;

endpackage

`default_nettype wire

// ==== source/exe_result_queue.sv ====
// result queue with credit flow control
`timescale 1ns/1ps
`default_nettype none

module exe_result_queue import exe_pkg::*; (
	input  wire logic                clk,
	input  wire logic                rst,
	input  wire logic                stage_valid_i,
	input  wire logic [RESULT_W-1:0] stage_entry_i,
	input  wire logic                mem_credit_i,
	output logic                     res_valid_o,
	output logic      [RESULT_W-1:0] res_entry_o,
	output logic                     issue_credit_o
);

	logic [RESULT_W-1:0] mem [QUEUE_DEPTH];
	logic [QPTR_W-1:0]   wr_ptr;
	logic [QPTR_W-1:0]   rd_ptr;
	logic [QCNT_W-1:0]   count;
	logic [MCRED_W-1:0]  credit_cnt;
	logic                full;
	logic                pop;

	assign full        = (count == QCNT_W'(QUEUE_DEPTH));
	assign res_valid_o = (count != '0) && (credit_cnt != '0);
	assign pop         = res_valid_o;
	assign res_entry_o = mem[rd_ptr];

	always_ff @(posedge clk) begin
		if (stage_valid_i) begin
			mem[wr_ptr] <= stage_entry_i;
		end
	end

	// depth is a power of two, pointers wrap on their own
	always_ff @(posedge clk) begin
		if (rst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (stage_valid_i) begin
				wr_ptr <= wr_ptr + QPTR_W'(1);
			end
			if (pop) begin
				rd_ptr <= rd_ptr + QPTR_W'(1);
			end
			case ({stage_valid_i, pop})
				2'b10:   count <= count + QCNT_W'(1);
				2'b01:   count <= count - QCNT_W'(1);
				default: count <= count;
			endcase
		end
	end

	// a credit return and a pop in one cycle cancel out
	always_ff @(posedge clk) begin
		if (rst) begin
			credit_cnt     <= MCRED_W'(MEM_CREDITS);
			issue_credit_o <= 1'b0;
		end else begin
			case ({mem_credit_i, pop})
				2'b10:   credit_cnt <= credit_cnt + MCRED_W'(1);
				2'b01:   credit_cnt <= credit_cnt - MCRED_W'(1);
				default: credit_cnt <= credit_cnt;
			endcase
			issue_credit_o <= pop;
		end
	end

	// decode credits cover the stage register, so a full queue never sees a write
	a_no_overflow: assert property (@(posedge clk) disable iff (rst)
		!(stage_valid_i && full));
	a_credit_max: assert property (@(posedge clk) disable iff (rst)
		credit_cnt <= MCRED_W'(MEM_CREDITS));

endmodule

`default_nettype wire

// ==== source/exe_stage.sv ====
// execute stage datapath
`timescale 1ns/1ps
`default_nettype none

module exe_stage import exe_pkg::*; (
	input  wire logic                    clk,
	input  wire logic                    rst,
	input  wire logic                    issue_valid_i,
	input  wire logic [XLEN-1:0]         reg1_i,
	input  wire logic [XLEN-1:0]         reg2_i,
	input  wire logic [XLEN-1:0]         pc_i,
	input  wire logic [XLEN-1:0]         imm_i,
	input  wire logic [XLEN-1:0]         csr_rdata_i,
	input  wire logic [ALU_OP_W-1:0]     alu_ctrl_i,
	input  wire logic [2*SEL_W-1:0]      alu_sel_i,
	input  wire logic [CSR_W-1:0]        csr_flag_i,
	input  wire logic [BR_W-1:0]         branch_type_i,
	input  wire logic [LOAD_W-1:0]       load_type_i,
	input  wire logic [STORE_W-1:0]      store_type_i,
	input  wire logic                    wd_i,
	input  wire logic [REG_ADDR_W-1:0]   wreg_i,
	output logic                         stage_valid_o,
	output logic      [RESULT_W-1:0]     stage_entry_o
);

	logic [XLEN-1:0] src1;
	logic [XLEN-1:0] src2;
	logic [XLEN-1:0] alu_result;
	logic            alu_less;
	logic            alu_zero;
	logic            branch_taken;
	logic [XLEN-1:0] csr_wdata;

	// first operand from the low select field
	always_comb begin
		case (alu_sel_i[SEL_W-1:0])
			SEL1_ZERO: src1 = '0;
			SEL1_REG1: src1 = reg1_i;
			SEL1_PC:   src1 = pc_i;
			SEL1_CSR:  src1 = csr_rdata_i;
			default:   src1 = '0;
		endcase
	end

	// second operand from the high select field
	always_comb begin
		case (alu_sel_i[2*SEL_W-1:SEL_W])
			SEL2_ZERO: src2 = '0;
			SEL2_REG2: src2 = reg2_i;
			SEL2_IMM:  src2 = imm_i;
			SEL2_FOUR: src2 = XLEN'(4);
			default:   src2 = '0;
		endcase
	end

	exe_alu alu_i (
		.src1_i     (src1),
		.src2_i     (src2),
		.alu_ctrl_i (alu_ctrl_i),
		.result_o   (alu_result),
		.less_o     (alu_less),
		.zero_o     (alu_zero)
	);

	// decode picks sub/slt or sltu so the less flag matches the branch
	always_comb begin
		case (branch_type_i)
			BR_NONE: branch_taken = 1'b0;
			BR_BEQ:  branch_taken = alu_zero;
			BR_BNE:  branch_taken = ~alu_zero;
			BR_BLT:  branch_taken = alu_less;
			BR_BGE:  branch_taken = ~alu_less;
			BR_BLTU: branch_taken = alu_less;
			BR_BGEU: branch_taken = ~alu_less;
			default: branch_taken = 1'b0;
		endcase
	end

	always_comb begin
		case (csr_flag_i)
			CSR_NONE: csr_wdata = '0;
			CSR_RW:   csr_wdata = reg1_i;
			CSR_RS:   csr_wdata = reg1_i | csr_rdata_i;
			default:  csr_wdata = '0;
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			stage_valid_o <= 1'b0;
		end else begin
			stage_valid_o <= issue_valid_i;
		end
	end

	// payload only, qualified by stage_valid_o
	always_ff @(posedge clk) begin
		if (issue_valid_i) begin
			stage_entry_o <= {alu_result, csr_wdata, csr_flag_i, pc_i, branch_taken,
				load_type_i, store_type_i, reg2_i, wreg_i, wd_i};
		end
	end

	a_valid_known: assert property (@(posedge clk) disable iff (rst)
		!$isunknown(stage_valid_o));

endmodule

`default_nettype wire

// ==== source/exe_top.sv ====
// execute stage top level
`timescale 1ns/1ps
`default_nettype none

module exe_top import exe_pkg::*; (
	input  wire logic                  clk,
	input  wire logic                  rst,
	input  wire logic                  issue_valid_i,
	input  wire logic [XLEN-1:0]       reg1_i,
	input  wire logic [XLEN-1:0]       reg2_i,
	input  wire logic [XLEN-1:0]       pc_i,
	input  wire logic [XLEN-1:0]       imm_i,
	input  wire logic [XLEN-1:0]       csr_rdata_i,
	input  wire logic [ALU_OP_W-1:0]   alu_ctrl_i,
	input  wire logic [2*SEL_W-1:0]    alu_sel_i,
	input  wire logic [CSR_W-1:0]      csr_flag_i,
	input  wire logic [BR_W-1:0]       branch_type_i,
	input  wire logic [LOAD_W-1:0]     load_type_i,
	input  wire logic [STORE_W-1:0]    store_type_i,
	input  wire logic                  wd_i,
	input  wire logic [REG_ADDR_W-1:0] wreg_i,
	output logic                       issue_credit_o,
	input  wire logic                  mem_credit_i,
	output logic                       res_valid_o,
	output logic      [XLEN-1:0]       alu_result_o,
	output logic      [XLEN-1:0]       csr_wdata_o,
	output logic      [CSR_W-1:0]      csr_type_o,
	output logic                       branch_taken_o,
	output logic      [LOAD_W-1:0]     load_type_o,
	output logic      [STORE_W-1:0]    store_type_o,
	output logic      [XLEN-1:0]       mem_wdata_o,
	output logic      [XLEN-1:0]       pc_o,
	output logic                       wd_o,
	output logic      [REG_ADDR_W-1:0] wreg_o
);

	logic                stage_valid;
	logic [RESULT_W-1:0] stage_entry;
	logic [RESULT_W-1:0] res_entry;

	exe_stage stage_i (
		.clk           (clk),
		.rst           (rst),
		.issue_valid_i (issue_valid_i),
		.reg1_i        (reg1_i),
		.reg2_i        (reg2_i),
		.pc_i          (pc_i),
		.imm_i         (imm_i),
		.csr_rdata_i   (csr_rdata_i),
		.alu_ctrl_i    (alu_ctrl_i),
		.alu_sel_i     (alu_sel_i),
		.csr_flag_i    (csr_flag_i),
		.branch_type_i (branch_type_i),
		.load_type_i   (load_type_i),
		.store_type_i  (store_type_i),
		.wd_i          (wd_i),
		.wreg_i        (wreg_i),
		.stage_valid_o (stage_valid),
		.stage_entry_o (stage_entry)
	);

	exe_result_queue queue_i (
		.clk            (clk),
		.rst            (rst),
		.stage_valid_i  (stage_valid),
		.stage_entry_i  (stage_entry),
		.mem_credit_i   (mem_credit_i),
		.res_valid_o    (res_valid_o),
		.res_entry_o    (res_entry),
		.issue_credit_o (issue_credit_o)
	);

	// same field order as the stage packs it
	assign {alu_result_o, csr_wdata_o, csr_type_o, pc_o, branch_taken_o,
		load_type_o, store_type_o, mem_wdata_o, wreg_o, wd_o} = res_entry;

endmodule

`default_nettype wire

// ==== verif/exe_model.svh ====
// execute stage reference model
`ifndef EXE_MODEL_SVH
`define EXE_MODEL_SVH

function automatic logic [XLEN-1:0] model_src1(input logic [SEL_W-1:0] sel,
		input logic [XLEN-1:0] reg1, pc, csr);
	case (sel)
		SEL1_REG1: return reg1;
		SEL1_PC:   return pc;
		SEL1_CSR:  return csr;
		default:   return '0;
	endcase
endfunction

function automatic logic [XLEN-1:0] model_src2(input logic [SEL_W-1:0] sel,
		input logic [XLEN-1:0] reg2, imm);
	case (sel)
		SEL2_REG2: return reg2;
		SEL2_IMM:  return imm;
		SEL2_FOUR: return XLEN'(4);
		default:   return '0;
	endcase
endfunction

function automatic logic [XLEN-1:0] model_alu(input logic [ALU_OP_W-1:0] op,
		input logic [XLEN-1:0] a, b);
	logic [4:0]      sh;
	logic [XLEN-1:0] fill;
	sh = b[4:0];
	// sign bits shifted in from the top
	fill = a[XLEN-1] ? ~({XLEN{1'b1}} >> sh) : '0;
	case (op)
		ALU_ADD:  return a + b;
		ALU_SUB:  return a - b;
		ALU_AND:  return a & b;
		ALU_OR:   return a | b;
		ALU_XOR:  return a ^ b;
		ALU_SLL:  return a << sh;
		ALU_SRL:  return a >> sh;
		ALU_SRA:  return (a >> sh) | fill;
		ALU_SLT:  return ($signed(a) < $signed(b)) ? XLEN'(1) : '0;
		ALU_SLTU: return (a < b) ? XLEN'(1) : '0;
		default:  return '0;
	endcase
endfunction

// rv32 branch semantics on the two register operands
function automatic logic model_branch(input logic [BR_W-1:0] bt, input logic [XLEN-1:0] a, b);
	case (bt)
		BR_BEQ:  return a == b;
		BR_BNE:  return a != b;
		BR_BLT:  return $signed(a) < $signed(b);
		BR_BGE:  return $signed(a) >= $signed(b);
		BR_BLTU: return a < b;
		BR_BGEU: return a >= b;
		default: return 1'b0;
	endcase
endfunction

function automatic logic [XLEN-1:0] model_csr(input logic [CSR_W-1:0] flag,
		input logic [XLEN-1:0] reg1, rdata);
	case (flag)
		CSR_RW:  return reg1;
		CSR_RS:  return reg1 | rdata;
		default: return '0;
	endcase
endfunction

`endif

// ==== verif/tb_exe_top.sv ====
// execute stage testbench
`timescale 1ns/1ps
`default_nettype none

module tb_exe_top import exe_pkg::*; ();

	`include "exe_model.svh"

	localparam int NUM_ISSUES     = 300;
	localparam int TIMEOUT_CYCLES = 4 * NUM_ISSUES + 200;

	typedef struct {
		logic [XLEN-1:0]       alu;
		logic [XLEN-1:0]       csr_wdata;
		logic [CSR_W-1:0]      csr_type;
		logic [XLEN-1:0]       pc;
		logic                  branch;
		logic [LOAD_W-1:0]     load;
		logic [STORE_W-1:0]    store;
		logic [XLEN-1:0]       mem_wdata;
		logic [REG_ADDR_W-1:0] wreg;
		logic                  wd;
	} exp_t;

	logic clk = 1'b0;
	logic rst;
	logic issue_valid_i;
	logic [XLEN-1:0] reg1_i;
	logic [XLEN-1:0] reg2_i;
	logic [XLEN-1:0] pc_i;
	logic [XLEN-1:0] imm_i;
	logic [XLEN-1:0] csr_rdata_i;
	logic [ALU_OP_W-1:0] alu_ctrl_i;
	logic [2*SEL_W-1:0] alu_sel_i;
	logic [CSR_W-1:0] csr_flag_i;
	logic [BR_W-1:0] branch_type_i;
	logic [LOAD_W-1:0] load_type_i;
	logic [STORE_W-1:0] store_type_i;
	logic wd_i;
	logic [REG_ADDR_W-1:0] wreg_i;
	logic issue_credit_o;
	logic mem_credit_i;
	logic res_valid_o;
	logic [XLEN-1:0] alu_result_o;
	logic [XLEN-1:0] csr_wdata_o;
	logic [CSR_W-1:0] csr_type_o;
	logic branch_taken_o;
	logic [LOAD_W-1:0] load_type_o;
	logic [STORE_W-1:0] store_type_o;
	logic [XLEN-1:0] mem_wdata_o;
	logic [XLEN-1:0] pc_o;
	logic wd_o;
	logic [REG_ADDR_W-1:0] wreg_o;

	exp_t  exp_q[$];
	string phase = "reset";
	int    issue_credits = QUEUE_DEPTH;
	int    mem_cred = MEM_CREDITS;
	int    num_issues = 0;
	int    num_results = 0;
	int    credit_returns = 0;
	int    value_errs = 0;
	int    proto_errs = 0;
	int    cycle_cnt = 0;
	logic  popped_prev = 1'b0;

	exe_top exe_top_i (.*);

	always #10 clk = ~clk;

	task automatic print_counts();
		$display("errors: value %0d, protocol %0d; issues %0d, results %0d",
			value_errs, proto_errs, num_issues, num_results);
	endtask

	// cycle limit guards against a stuck credit loop
	always @(posedge clk) begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt == TIMEOUT_CYCLES) begin
			$display("timeout after %0d cycles in phase %s", cycle_cnt, phase);
			print_counts();
			$display("STATUS: FAIL");
			$finish;
		end
	end

	task automatic compare_field(input string name, input logic [XLEN-1:0] exp_v,
			input logic [XLEN-1:0] act_v);
		assert (act_v === exp_v) else begin
			$display("[ERROR] %s %s (result %0d): expected %h actual %h",
				phase, name, num_results, exp_v, act_v);
			value_errs++;
		end
	endtask

	function automatic logic [XLEN-1:0] pick_operand();
		case ($urandom % 8)
			0:       return '0;
			1:       return XLEN'(1);
			2:       return 32'h7fff_ffff;
			3:       return 32'h8000_0000;
			4:       return 32'hffff_ffff;
			default: return $urandom;
		endcase
	endfunction

	task automatic check_result();
		exp_t e;
		e = exp_q.pop_front();
		compare_field("alu_result", e.alu, alu_result_o);
		compare_field("csr_wdata", e.csr_wdata, csr_wdata_o);
		compare_field("csr_type", XLEN'(e.csr_type), XLEN'(csr_type_o));
		compare_field("pc", e.pc, pc_o);
		compare_field("branch_taken", XLEN'(e.branch), XLEN'(branch_taken_o));
		compare_field("load_type", XLEN'(e.load), XLEN'(load_type_o));
		compare_field("store_type", XLEN'(e.store), XLEN'(store_type_o));
		compare_field("mem_wdata", e.mem_wdata, mem_wdata_o);
		compare_field("wreg", XLEN'(e.wreg), XLEN'(wreg_o));
		compare_field("wd", XLEN'(e.wd), XLEN'(wd_o));
		num_results++;
	endtask

	task automatic issue_one();
		logic [XLEN-1:0]       r1;
		logic [XLEN-1:0]       r2;
		logic [XLEN-1:0]       pc;
		logic [XLEN-1:0]       imm;
		logic [XLEN-1:0]       csr;
		logic [ALU_OP_W-1:0]   op;
		logic [2*SEL_W-1:0]    sel;
		logic [BR_W-1:0]       br;
		logic [CSR_W-1:0]      cf;
		exp_t                  e;
		r1 = pick_operand();
		r2 = ($urandom % 8 == 0) ? r1 : pick_operand();
		pc = $urandom & 32'hffff_fffc;
		imm = pick_operand();
		csr = $urandom;
		cf = CSR_W'($urandom % 3);
		br = ($urandom % 2 == 0) ? BR_NONE : BR_W'(32'd1 + $urandom % 6);
		// branches get the compare op and register operands decode would give them
		if (br == BR_NONE) begin
			op = ALU_OP_W'($urandom % 10);
			sel = (2*SEL_W)'($urandom);
		end else begin
			op = (br == BR_BLTU || br == BR_BGEU) ? ALU_SLTU : ALU_SUB;
			sel = {SEL2_REG2, SEL1_REG1};
		end
		e.alu = model_alu(op, model_src1(sel[SEL_W-1:0], r1, pc, csr),
			model_src2(sel[2*SEL_W-1:SEL_W], r2, imm));
		e.csr_wdata = model_csr(cf, r1, csr);
		e.csr_type = cf;
		e.pc = pc;
		e.branch = model_branch(br, r1, r2);
		e.load = LOAD_W'($urandom);
		e.store = STORE_W'($urandom);
		e.mem_wdata = r2;
		e.wreg = REG_ADDR_W'($urandom);
		e.wd = 1'($urandom);
		exp_q.push_back(e);
		issue_valid_i <= 1'b1;
		reg1_i <= r1;
		reg2_i <= r2;
		pc_i <= pc;
		imm_i <= imm;
		csr_rdata_i <= csr;
		alu_ctrl_i <= op;
		alu_sel_i <= sel;
		csr_flag_i <= cf;
		branch_type_i <= br;
		load_type_i <= e.load;
		store_type_i <= e.store;
		wd_i <= e.wd;
		wreg_i <= e.wreg;
		issue_credits--;
		num_issues++;
	endtask

	// observe at the falling edge, drive after the rising edge
	task automatic step(input int issue_pct, input int credit_pct);
		@(negedge clk);
		assert (issue_credit_o === popped_prev) else begin
			$display("issue_credit_o did not follow the previous pop in phase %s", phase);
			proto_errs++;
		end
		if (issue_credit_o) begin
			issue_credits++;
			credit_returns++;
		end
		if (res_valid_o) begin
			assert (mem_cred > 0) else begin
				$display("res_valid_o high with no memory credit in phase %s", phase);
				proto_errs++;
			end
			assert (exp_q.size() != 0) else begin
				$display("result delivered with no issue outstanding in phase %s", phase);
				proto_errs++;
			end
			if (exp_q.size() != 0) begin
				check_result();
			end
		end
		popped_prev = res_valid_o;
		mem_cred = mem_cred + (mem_credit_i ? 1 : 0) - (res_valid_o ? 1 : 0);
		@(posedge clk);
		issue_valid_i <= 1'b0;
		mem_credit_i <= 1'b0;
		if (issue_credits > 0 && ($urandom % 100) < issue_pct) begin
			issue_one();
		end
		if (mem_cred < MEM_CREDITS && ($urandom % 100) < credit_pct) begin
			mem_credit_i <= 1'b1;
		end
	endtask

	initial begin
		void'($urandom(31));
		rst = 1'b1;
		issue_valid_i = 1'b0;
		reg1_i = '0;
		reg2_i = '0;
		pc_i = '0;
		imm_i = '0;
		csr_rdata_i = '0;
		alu_ctrl_i = ALU_ADD;
		alu_sel_i = '0;
		csr_flag_i = CSR_NONE;
		branch_type_i = BR_NONE;
		load_type_i = '0;
		store_type_i = '0;
		wd_i = 1'b0;
		wreg_i = '0;
		mem_credit_i = 1'b0;
		repeat (8) @(posedge clk);
		rst <= 1'b0;

		phase = "idle";
		repeat (4) step(0, 0);

		// memory credits withheld, decode must stall with the queue full
		phase = "stall";
		repeat (30) step(100, 0);
		compare_field("issue_credits", '0, XLEN'(issue_credits));
		compare_field("queued", XLEN'(QUEUE_DEPTH), XLEN'(num_issues - num_results));
		compare_field("delivered", XLEN'(MEM_CREDITS), XLEN'(num_results));

		phase = "random";
		while (num_issues < NUM_ISSUES) begin
			step(60, 70);
		end

		phase = "drain";
		while (exp_q.size() != 0) begin
			step(0, 100);
		end
		repeat (4) step(0, 100);
		compare_field("result_count", XLEN'(num_issues), XLEN'(num_results));
		compare_field("credit_returns", XLEN'(num_results), XLEN'(credit_returns));
		compare_field("final_issue_credits", XLEN'(QUEUE_DEPTH), XLEN'(issue_credits));

		print_counts();
		if (value_errs == 0 && proto_errs == 0) begin
			$display("STATUS: PASS");
		end else begin
			$display("STATUS: FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire
